//--- rtl/iob_soc_pkg.sv
`default_nettype none

package iob_soc_pkg;

   // native bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // internal sram of 1024 words, boot rom of 64 words
   localparam int SRAM_ADDR_W    = 12;
   localparam int BOOTROM_ADDR_W = 8;

   // boot image sits at the top of the sram
   localparam int BOOT_OFFSET = (1 << SRAM_ADDR_W) - (1 << BOOTROM_ADDR_W);

   // data bus slave select, 0 memory and 1 boot register
   localparam int P_SEL_BIT = 30;

   // request from master to slave
   typedef struct packed {
      logic                valid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
   } iob_req_t;

   // response from slave to master
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_resp_t;

   // boot controller states
   typedef enum logic [1:0] {
      BOOT_COPY,
      BOOT_RUN,
      BOOT_APP
   } boot_state_e;

endpackage

`default_nettype wire

//--- rtl/iob_split.sv
`timescale 1ns/1ps
`default_nettype none

module iob_split #(
   parameter int N_SLAVES = 2
) (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   cke_i,
   input  iob_soc_pkg::iob_req_t  m_req_i,
   output iob_soc_pkg::iob_resp_t m_resp_o,
   output iob_soc_pkg::iob_req_t  s_req_o  [N_SLAVES],
   input  iob_soc_pkg::iob_resp_t s_resp_i [N_SLAVES]
);
   import iob_soc_pkg::*;

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [SEL_W-1:0] sel;
   logic [SEL_W-1:0] sel_q;
   logic             rd_acc;

   // slave index taken from the address bits at P_SEL_BIT
   assign sel    = m_req_i.addr[P_SEL_BIT +: SEL_W];
   assign rd_acc = m_req_i.valid & cke_i & ~|m_req_i.wstrb;

   // same request to all slaves, valid only to the addressed one
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_req_o[i]       = m_req_i;
         s_req_o[i].valid = m_req_i.valid & (sel == SEL_W'(i));
      end
   end

   // remember who owes the read data
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= '0;
      end else if (rd_acc) begin
         sel_q <= sel;
      end
   end

   assign m_resp_o.rdata  = s_resp_i[sel_q].rdata;
   assign m_resp_o.rvalid = s_resp_i[sel_q].rvalid;
   assign m_resp_o.ready  = s_resp_i[sel].ready;

   // one response per accepted read
   rvalid_single_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      m_resp_o.rvalid && !rd_acc |=> !m_resp_o.rvalid
   );

endmodule

`default_nettype wire

//--- rtl/iob_soc_sram.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_sram (
   input  logic                                  clk_i,
   input  logic                                  arst_n_i,
   input  logic                                  cke_i,
   // instruction port
   input  logic [iob_soc_pkg::SRAM_ADDR_W-3:0]   i_addr_i,
   input  logic                                  i_valid_i,
   output logic [iob_soc_pkg::DATA_W-1:0]        i_rdata_o,
   output logic                                  i_rvalid_o,
   // data port
   input  logic                                  d_valid_i,
   input  logic [iob_soc_pkg::SRAM_ADDR_W-3:0]   d_addr_i,
   input  logic [iob_soc_pkg::DATA_W-1:0]        d_wdata_i,
   input  logic [iob_soc_pkg::DATA_W/8-1:0]      d_wstrb_i,
   output logic [iob_soc_pkg::DATA_W-1:0]        d_rdata_o,
   output logic                                  d_rvalid_o
);
   import iob_soc_pkg::*;

   logic [DATA_W-1:0] mem [2**(SRAM_ADDR_W-2)];
   logic              d_write;
   logic              i_rvalid_q;
   logic              d_rvalid_q;

   assign d_write = d_valid_i & |d_wstrb_i;

   // instruction port is read only
   always_ff @(posedge clk_i) begin
      if (cke_i && i_valid_i) begin
         i_rdata_o <= mem[i_addr_i];
      end
   end

   // data port, byte lanes follow wstrb
   always_ff @(posedge clk_i) begin
      if (cke_i && d_valid_i) begin
         if (d_write) begin
            for (int b = 0; b < DATA_W/8; b++) begin
               if (d_wstrb_i[b]) begin
                  mem[d_addr_i][b*8 +: 8] <= d_wdata_i[b*8 +: 8];
               end
            end
         end else begin
            d_rdata_o <= mem[d_addr_i];
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else if (cke_i) begin
         i_rvalid_q <= i_valid_i;
         d_rvalid_q <= d_valid_i & ~d_write;
      end
   end

   // responses only show on enabled cycles
   assign i_rvalid_o = i_rvalid_q & cke_i;
   assign d_rvalid_o = d_rvalid_q & cke_i;

endmodule

`default_nettype wire

//--- rtl/iob_soc_boot_ctr.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_boot_ctr (
   input  logic                                   clk_i,
   input  logic                                   arst_n_i,
   input  logic                                   cke_i,
   input  iob_soc_pkg::iob_req_t                  req_i,
   output iob_soc_pkg::iob_resp_t                 resp_o,
   output logic                                   rom_r_valid_o,
   output logic [iob_soc_pkg::BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [iob_soc_pkg::DATA_W-1:0]         rom_r_rdata_i,
   output logic                                   wr_valid_o,
   output logic [iob_soc_pkg::SRAM_ADDR_W-3:0]    wr_addr_o,
   output logic [iob_soc_pkg::DATA_W-1:0]         wr_data_o,
   output logic                                   boot_o,
   output logic                                   cpu_reset_o
);
   import iob_soc_pkg::*;

   boot_state_e               state_q;
   boot_state_e               state_nxt;
   logic [BOOTROM_ADDR_W-2:0] req_cnt_q;
   logic [BOOTROM_ADDR_W-3:0] wr_idx_q;
   logic                      req_done;
   logic                      copy_last;
   logic                      req_acc;
   logic                      reg_write;
   logic                      reg_rvalid_q;
   logic                      reg_rdata_q;

   // msb of the counter marks all rom words requested
   assign req_done  = req_cnt_q[BOOTROM_ADDR_W-2];
   assign copy_last = wr_valid_o & (&wr_idx_q);
   assign req_acc   = req_i.valid & cke_i;
   assign reg_write = req_acc & |req_i.wstrb;

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         BOOT_COPY: begin
            if (copy_last) begin
               state_nxt = BOOT_RUN;
            end
         end
         BOOT_RUN: begin
            if (reg_write && !req_i.wdata[0]) begin
               state_nxt = BOOT_APP;
            end
         end
         default: state_nxt = state_q;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q       <= BOOT_COPY;
         req_cnt_q     <= '0;
         rom_r_valid_o <= 1'b0;
         rom_r_addr_o  <= '0;
         wr_valid_o    <= 1'b0;
         wr_idx_q      <= '0;
         cpu_reset_o   <= 1'b1;
      end else if (cke_i) begin
         state_q       <= state_nxt;
         // held through the copy, one pulse when boot ends
         cpu_reset_o   <= (state_nxt == BOOT_COPY) |
                          (state_q == BOOT_RUN && state_nxt == BOOT_APP);
         rom_r_valid_o <= (state_q == BOOT_COPY) & ~req_done;
         if (state_q == BOOT_COPY && !req_done) begin
            rom_r_addr_o <= req_cnt_q[BOOTROM_ADDR_W-3:0];
            req_cnt_q    <= req_cnt_q + 1'b1;
         end
         // rom data lands one cycle after its request
         wr_valid_o <= rom_r_valid_o;
         wr_idx_q   <= rom_r_addr_o;
      end
   end

   assign wr_data_o = rom_r_rdata_i;
   assign wr_addr_o = (SRAM_ADDR_W-2)'(BOOT_OFFSET >> 2) + (SRAM_ADDR_W-2)'(wr_idx_q);
   assign boot_o    = (state_q == BOOT_RUN);

   // boot register read port
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         reg_rvalid_q <= 1'b0;
      end else if (cke_i) begin
         reg_rvalid_q <= req_acc & ~|req_i.wstrb;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_acc) begin
         reg_rdata_q <= boot_o;
      end
   end

   assign resp_o.rdata  = {{(DATA_W-1){1'b0}}, reg_rdata_q};
   assign resp_o.rvalid = reg_rvalid_q & cke_i;
   assign resp_o.ready  = 1'b1;

   rom_only_in_copy_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      rom_r_valid_o |-> state_q == BOOT_COPY
   );

endmodule

`default_nettype wire

//--- rtl/iob_soc_int_mem.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_int_mem (
   input  logic                                   clk_i,
   input  logic                                   arst_n_i,
   input  logic                                   cke_i,
   // instruction bus
   input  iob_soc_pkg::iob_req_t                  i_req_i,
   output iob_soc_pkg::iob_resp_t                 i_resp_o,
   // data bus
   input  iob_soc_pkg::iob_req_t                  d_req_i,
   output iob_soc_pkg::iob_resp_t                 d_resp_o,
   // boot register
   input  iob_soc_pkg::iob_req_t                  boot_req_i,
   output iob_soc_pkg::iob_resp_t                 boot_resp_o,
   // boot rom
   output logic                                   rom_r_valid_o,
   output logic [iob_soc_pkg::BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [iob_soc_pkg::DATA_W-1:0]         rom_r_rdata_i,
   output logic                                   boot_o,
   output logic                                   cpu_reset_o
);
   import iob_soc_pkg::*;

   logic                   wr_valid;
   logic [SRAM_ADDR_W-3:0] wr_addr;
   logic [DATA_W-1:0]      wr_data;
   logic [SRAM_ADDR_W-1:0] i_byte_addr;
   logic                   sram_d_valid;
   logic [SRAM_ADDR_W-3:0] sram_d_addr;
   logic [DATA_W-1:0]      sram_d_wdata;
   logic [DATA_W/8-1:0]    sram_d_wstrb;
   logic [DATA_W-1:0]      i_rdata;
   logic                   i_rvalid;
   logic [DATA_W-1:0]      d_rdata;
   logic                   d_rvalid;

   iob_soc_boot_ctr boot_ctr0 (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cke_i        (cke_i),
      .req_i        (boot_req_i),
      .resp_o       (boot_resp_o),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .wr_valid_o   (wr_valid),
      .wr_addr_o    (wr_addr),
      .wr_data_o    (wr_data),
      .boot_o       (boot_o),
      .cpu_reset_o  (cpu_reset_o)
   );

   // fetches go to the boot image while booting
   assign i_byte_addr = i_req_i.addr[SRAM_ADDR_W-1:0] +
                        (boot_o ? SRAM_ADDR_W'(BOOT_OFFSET) : '0);

   // copy writes own the data port
   always_comb begin
      if (wr_valid) begin
         sram_d_valid = 1'b1;
         sram_d_addr  = wr_addr;
         sram_d_wdata = wr_data;
         sram_d_wstrb = '1;
      end else begin
         sram_d_valid = d_req_i.valid;
         sram_d_addr  = d_req_i.addr[SRAM_ADDR_W-1:2];
         sram_d_wdata = d_req_i.wdata;
         sram_d_wstrb = d_req_i.wstrb;
      end
   end

   iob_soc_sram sram0 (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .cke_i     (cke_i),
      .i_addr_i  (i_byte_addr[SRAM_ADDR_W-1:2]),
      .i_valid_i (i_req_i.valid),
      .i_rdata_o (i_rdata),
      .i_rvalid_o(i_rvalid),
      .d_valid_i (sram_d_valid),
      .d_addr_i  (sram_d_addr),
      .d_wdata_i (sram_d_wdata),
      .d_wstrb_i (sram_d_wstrb),
      .d_rdata_o (d_rdata),
      .d_rvalid_o(d_rvalid)
   );

   assign i_resp_o = '{rdata: i_rdata, rvalid: i_rvalid, ready: 1'b1};
   assign d_resp_o = '{rdata: d_rdata, rvalid: d_rvalid, ready: 1'b1};

   // cpu is still in reset while the copy runs
   no_dbus_during_copy_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      wr_valid && cke_i |-> !d_req_i.valid
   );

endmodule

`default_nettype wire

//--- rtl/iob_soc.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc (
   input  logic                                   clk_i,
   input  logic                                   arst_n_i,
   input  logic                                   cke_i,
   // instruction bus
   input  iob_soc_pkg::iob_req_t                  ibus_req_i,
   output iob_soc_pkg::iob_resp_t                 ibus_resp_o,
   // data bus
   input  iob_soc_pkg::iob_req_t                  dbus_req_i,
   output iob_soc_pkg::iob_resp_t                 dbus_resp_o,
   // boot rom
   output logic                                   rom_r_valid_o,
   output logic [iob_soc_pkg::BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [iob_soc_pkg::DATA_W-1:0]         rom_r_rdata_i,
   // cpu control
   output logic                                   boot_o,
   output logic                                   cpu_reset_o
);
   import iob_soc_pkg::*;

   // slave 0 memory, slave 1 boot register
   iob_req_t  slv_req  [2];
   iob_resp_t slv_resp [2];

   iob_split #(
      .N_SLAVES(2)
   ) pbus_split (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .cke_i   (cke_i),
      .m_req_i (dbus_req_i),
      .m_resp_o(dbus_resp_o),
      .s_req_o (slv_req),
      .s_resp_i(slv_resp)
   );

   iob_soc_int_mem int_mem0 (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cke_i        (cke_i),
      .i_req_i      (ibus_req_i),
      .i_resp_o     (ibus_resp_o),
      .d_req_i      (slv_req[0]),
      .d_resp_o     (slv_resp[0]),
      .boot_req_i   (slv_req[1]),
      .boot_resp_o  (slv_resp[1]),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .boot_o       (boot_o),
      .cpu_reset_o  (cpu_reset_o)
   );

endmodule

`default_nettype wire

//--- dv/iob_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iob_soc_tb;
   import iob_soc_pkg::*;

   localparam int ROM_WORDS      = 2 ** (BOOTROM_ADDR_W - 2);
   localparam int MEM_WORDS      = 2 ** (SRAM_ADDR_W - 2);
   localparam int BOOT_BASE      = BOOT_OFFSET / 4;
   localparam int N_WORDS        = 8;
   localparam int TIMEOUT_CYCLES = 4000;
   localparam logic [ADDR_W-1:0] BOOT_REG_ADDR = ADDR_W'(1) << P_SEL_BIT;

   logic                      clk_i = 1'b0;
   logic                      arst_n_i;
   logic                      cke_i;
   iob_req_t                  ibus_req;
   iob_resp_t                 ibus_resp;
   iob_req_t                  dbus_req;
   iob_resp_t                 dbus_resp;
   logic                      rom_r_valid;
   logic [BOOTROM_ADDR_W-3:0] rom_r_addr;
   logic [DATA_W-1:0]         rom_rdata = '0;
   logic                      boot;
   logic                      cpu_reset;

   logic [DATA_W-1:0] rom   [ROM_WORDS];
   logic [DATA_W-1:0] model [MEM_WORDS];
   logic [9:0]        wr_idx [N_WORDS];
   logic [31:0]       lfsr_state = 32'h42a9;
   int unsigned       cycle_cnt = 0;

   iob_soc i_iob_soc (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cke_i        (cke_i),
      .ibus_req_i   (ibus_req),
      .ibus_resp_o  (ibus_resp),
      .dbus_req_i   (dbus_req),
      .dbus_resp_o  (dbus_resp),
      .rom_r_valid_o(rom_r_valid),
      .rom_r_addr_o (rom_r_addr),
      .rom_r_rdata_i(rom_rdata),
      .boot_o       (boot),
      .cpu_reset_o  (cpu_reset)
   );

   always #2 clk_i = ~clk_i;

   // boot rom model answers one cycle after the request
   always @(posedge clk_i) begin
      if (cke_i && rom_r_valid) begin
         rom_rdata <= rom[rom_r_addr];
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $fatal(1, "run stopped by the watchdog");
      end
   end

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      int          i;
      val = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val        = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   function automatic iob_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
                                         input logic [3:0] wstrb);
      iob_req_t req;
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      return req;
   endfunction

   // only enabled byte lanes take the new data
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strb);
      logic [31:0] res;
      int          b;
      res = old_word;
      for (b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   // the write is taken on the second edge and returns no read data
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
      @(posedge clk_i);
      dbus_req <= make_req(addr, wdata, wstrb);
      @(posedge clk_i);
      dbus_req <= '0;
      #1;
      check_value("dbus rvalid after write", 32'(dbus_resp.rvalid), 32'd0);
   endtask

   task automatic bus_read(input logic use_ibus, input logic [31:0] addr,
                           output logic [31:0] data);
      @(posedge clk_i);
      if (use_ibus) begin
         ibus_req <= make_req(addr, '0, '0);
      end else begin
         dbus_req <= make_req(addr, '0, '0);
      end
      @(posedge clk_i);
      ibus_req <= '0;
      dbus_req <= '0;
      #1;
      while (!(use_ibus ? ibus_resp.rvalid : dbus_resp.rvalid)) begin
         @(posedge clk_i);
         #1;
      end
      check_value("bus ready", 32'(use_ibus ? ibus_resp.ready : dbus_resp.ready), 32'd1);
      data = use_ibus ? ibus_resp.rdata : dbus_resp.rdata;
   endtask

   task automatic check_boot_copy();
      int          cycles;
      int          k;
      logic [31:0] data;
      cycles = 0;
      while (cpu_reset) begin
         check_value("boot_o during copy", 32'(boot), 32'd0);
         // one rom request per cycle after the first
         check_value("rom_r_valid_o during copy", 32'(rom_r_valid),
                     32'(cycles >= 1 && cycles <= ROM_WORDS));
         if (rom_r_valid) begin
            check_value("rom_r_addr_o during copy", 32'(rom_r_addr), 32'(cycles - 1));
         end
         @(posedge clk_i);
         #1;
         cycles++;
      end
      check_value("copy cycles", 32'(cycles), 32'd66);
      check_value("boot_o after copy", 32'(boot), 32'd1);
      // fetches land in the boot image
      for (k = 0; k < ROM_WORDS; k++) begin
         bus_read(1'b1, 32'(4 * k), data);
         check_value($sformatf("ibus rdata @%0h", 4 * k), data, rom[k]);
      end
   endtask

   task automatic check_copy_placement();
      int          k;
      logic [31:0] addr;
      logic [31:0] data;
      for (k = 0; k < ROM_WORDS; k++) begin
         // low address bits vary but the word stays the same
         addr = 32'(BOOT_OFFSET + 4 * k + (k % 4));
         bus_read(1'b0, addr, data);
         check_value($sformatf("dbus rdata @%h", addr), data, model[BOOT_BASE + k]);
      end
   endtask

   task automatic check_strobe_writes();
      int          n;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic [31:0] data;
      for (n = 0; n < N_WORDS; n++) begin
         wr_idx[n] = 10'(rand_bits(10) % BOOT_BASE);
         wdata     = rand_bits(32);
         bus_write({20'b0, wr_idx[n], 2'b00}, wdata, 4'hf);
         model[wr_idx[n]] = wdata;
      end
      for (n = 0; n < N_WORDS; n++) begin
         wdata = rand_bits(32);
         wstrb = 4'(rand_bits(4));
         if (wstrb == 4'h0) begin
            wstrb = 4'h1;
         end
         bus_write({20'b0, wr_idx[n], 2'b00}, wdata, wstrb);
         model[wr_idx[n]] = merge_bytes(model[wr_idx[n]], wdata, wstrb);
      end
      for (n = 0; n < N_WORDS; n++) begin
         bus_read(1'b0, {20'b0, wr_idx[n], 2'b00}, data);
         check_value($sformatf("dbus rdata word %0d", wr_idx[n]), data, model[wr_idx[n]]);
      end
   endtask

   task automatic check_boot_reg();
      logic [31:0] data;
      bus_read(1'b0, BOOT_REG_ADDR, data);
      check_value("boot register", data, 32'd1);
      check_value("cpu_reset_o before release", 32'(cpu_reset), 32'd0);
      bus_write(BOOT_REG_ADDR, 32'h0, 4'hf);
      check_value("cpu_reset_o pulse", 32'(cpu_reset), 32'd1);
      check_value("boot_o after clear", 32'(boot), 32'd0);
      @(posedge clk_i);
      #1;
      check_value("cpu_reset_o after pulse", 32'(cpu_reset), 32'd0);
      bus_read(1'b0, BOOT_REG_ADDR, data);
      check_value("boot register after clear", data, 32'd0);
      // flag stays clear until the next reset
      bus_write(BOOT_REG_ADDR, 32'h1, 4'hf);
      check_value("cpu_reset_o after set", 32'(cpu_reset), 32'd0);
      check_value("boot_o after set", 32'(boot), 32'd0);
      bus_read(1'b0, BOOT_REG_ADDR, data);
      check_value("boot register after set", data, 32'd0);
   endtask

   task automatic check_app_fetch();
      int          n;
      logic [31:0] data;
      for (n = 0; n < N_WORDS; n++) begin
         bus_read(1'b1, {20'b0, wr_idx[n], 2'b00}, data);
         check_value($sformatf("ibus rdata word %0d", wr_idx[n]), data, model[wr_idx[n]]);
      end
   endtask

   task automatic check_clock_enable(input logic [9:0] idx);
      int          k;
      logic [31:0] data;
      // the read is taken on the edge that drops cke_i
      @(posedge clk_i);
      dbus_req <= make_req({20'b0, idx, 2'b00}, '0, '0);
      @(posedge clk_i);
      cke_i    <= 1'b0;
      dbus_req <= make_req({20'b0, idx, 2'b00}, ~model[idx], 4'hf);
      for (k = 0; k < 5; k++) begin
         @(posedge clk_i);
         #1;
         check_value("dbus rvalid while frozen", 32'(dbus_resp.rvalid), 32'd0);
      end
      @(posedge clk_i);
      cke_i    <= 1'b1;
      dbus_req <= '0;
      #1;
      // pending read answers on the first enabled cycle
      check_value("dbus rvalid after freeze", 32'(dbus_resp.rvalid), 32'd1);
      check_value("dbus rdata held over freeze", dbus_resp.rdata, model[idx]);
      bus_read(1'b0, {20'b0, idx, 2'b00}, data);
      check_value("dbus rdata after freeze", data, model[idx]);
   endtask

   initial begin
      int k;
      arst_n_i = 1'b0;
      cke_i    = 1'b1;
      ibus_req = '0;
      dbus_req = '0;
      for (k = 0; k < ROM_WORDS; k++) begin
         rom[k]               = rand_bits(32);
         model[BOOT_BASE + k] = rom[k];
      end
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      check_boot_copy();
      check_copy_placement();
      check_strobe_writes();
      check_boot_reg();
      check_app_fetch();
      check_clock_enable(wr_idx[0]);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
rtl/iob_soc_pkg.sv
rtl/iob_split.sv
rtl/iob_soc_sram.sv
rtl/iob_soc_boot_ctr.sv
rtl/iob_soc_int_mem.sv
rtl/iob_soc.sv
dv/iob_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module iob_soc_tb -f all.f -Mdir obj_dir &&
./obj_dir/Viob_soc_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^>>> PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
